// File: src/cpu_pkg.sv
// Pipelined CPU shared types
package cpu_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   parameter int DATA_W      = 32;
   parameter int REG_ADDR_W  = 5;
   parameter int IMEM_ADDR_W = 9;
   parameter int DMEM_ADDR_W = 10;

   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   //////////////////////////////
   // Encodings
   //////////////////////////////
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2B
   } opcode_e;

   typedef enum logic [5:0] {
      F_ADD = 6'h20,
      F_SUB = 6'h22,
      F_AND = 6'h24,
      F_OR  = 6'h25,
      F_SLT = 6'h2A
   } funct_e;

   // Operation class handed from decode to execute
   typedef enum logic [1:0] {
      ALUOP_ADD   = 2'd0,
      ALUOP_SUB   = 2'd1,
      ALUOP_FUNCT = 2'd2
   } alu_op_e;

   typedef enum logic [3:0] {
      AC_AND = 4'd0,
      AC_OR  = 4'd1,
      AC_ADD = 4'd2,
      AC_SUB = 4'd6,
      AC_SLT = 4'd7
   } alu_ctrl_e;

   //////////////////////////////
   // Stage boundaries
   //////////////////////////////
   typedef struct packed {
      logic    reg_dst;
      logic    alu_src;
      alu_op_e alu_op;
      logic    branch;
      logic    jump;
      logic    mem_read;
      logic    mem_write;
      logic    mem_2_reg;
      logic    reg_write;
   } ctrl_t;

   typedef struct packed {
      word_t updated_pc;
      word_t instruction;
   } if_id_t;

   typedef struct packed {
      ctrl_t       ctrl;
      word_t       updated_pc;
      word_t       rs_data;
      word_t       rt_data;
      word_t       imm_ext;
      reg_addr_t   rs;
      reg_addr_t   rt;
      reg_addr_t   rd;
      logic [5:0]  funct;
      logic [25:0] jump_index;
   } id_ex_t;

   typedef struct packed {
      logic      reg_write;
      logic      mem_2_reg;
      logic      mem_read;
      logic      mem_write;
      logic      branch;
      logic      jump;
      logic      zero;
      word_t     branch_pc;
      word_t     jump_pc;
      word_t     alu_result;
      word_t     store_data;
      reg_addr_t waddr;
   } ex_mem_t;

   typedef struct packed {
      logic      reg_write;
      logic      mem_2_reg;
      word_t     alu_result;
      word_t     load_data;
      reg_addr_t waddr;
   } mem_wb_t;

   // Write-back result, fed back to decode and execute
   typedef struct packed {
      logic      reg_write;
      reg_addr_t waddr;
      word_t     wdata;
   } wb_t;

   typedef struct packed {
      logic  take_branch;
      logic  take_jump;
      word_t branch_pc;
      word_t jump_pc;
   } redirect_t;

endpackage

// File: src/fetch_stage.sv
// Instruction fetch stage
`timescale 1ns/10ps

module fetch_stage #(
   parameter int IMEM_ADDR_W = cpu_pkg::IMEM_ADDR_W
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   enable,
   input  cpu_pkg::redirect_t     redirect,
   input  logic                   imem_wen,
   input  logic [IMEM_ADDR_W-1:0] imem_addr,
   input  cpu_pkg::word_t         imem_wdata,
   output cpu_pkg::if_id_t        if_id
);
   import cpu_pkg::*;

   word_t pc;
   word_t pc_plus4;
   word_t next_pc;
   word_t instruction;

   word_t imem [2**IMEM_ADDR_W];

   //////////////////////////////
   // Program counter
   //////////////////////////////
   assign pc_plus4 = pc + 32'd4;

   // Jump wins over branch, both over sequential
   always_comb begin
      if (redirect.take_jump) begin
         next_pc = redirect.jump_pc;
      end else if (redirect.take_branch) begin
         next_pc = redirect.branch_pc;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc <= '0;
      end else if (enable) begin
         pc <= next_pc;
      end
   end

   //////////////////////////////
   // Instruction memory
   //////////////////////////////
   // Loaded from outside only
   always_ff @(posedge clk) begin
      if (imem_wen) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // Word address, byte offset dropped
   assign instruction = imem[pc[IMEM_ADDR_W+1:2]];

   //////////////////////////////
   // IF/ID register
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         if_id <= '0;
      end else if (enable) begin
         if_id.updated_pc  <= pc_plus4;
         if_id.instruction <= instruction;
      end
   end

endmodule

// File: src/decode_stage.sv
// Instruction decode stage
`timescale 1ns/10ps

module decode_stage (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            enable,
   input  cpu_pkg::if_id_t if_id,
   input  cpu_pkg::wb_t    wb,
   output cpu_pkg::id_ex_t id_ex
);
   import cpu_pkg::*;

   ctrl_t     ctrl;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;
   word_t     rs_data;
   word_t     rt_data;
   word_t     imm_ext;

   word_t regs [2**REG_ADDR_W];

   assign rs = if_id.instruction[25:21];
   assign rt = if_id.instruction[20:16];
   assign rd = if_id.instruction[15:11];

   //////////////////////////////
   // Control decode
   //////////////////////////////
   always_comb begin
      ctrl = '0;
      case (opcode_e'(if_id.instruction[31:26]))
         OP_RTYPE: begin
            ctrl.reg_dst   = 1'b1;
            ctrl.alu_op    = ALUOP_FUNCT;
            ctrl.reg_write = 1'b1;
         end
         OP_ADDI: begin
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = ALUOP_ADD;
            ctrl.reg_write = 1'b1;
         end
         OP_LW: begin
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = ALUOP_ADD;
            ctrl.mem_read  = 1'b1;
            ctrl.mem_2_reg = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         OP_SW: begin
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = ALUOP_ADD;
            ctrl.mem_write = 1'b1;
         end
         // Compare by subtraction, zero flag decides
         OP_BEQ: begin
            ctrl.alu_op = ALUOP_SUB;
            ctrl.branch = 1'b1;
         end
         OP_J: begin
            ctrl.jump = 1'b1;
         end
         default: begin
            ctrl = '0;
         end
      endcase
   end

   //////////////////////////////
   // Register file
   //////////////////////////////
   // r0 is never written
   always_ff @(posedge clk) begin
      if (enable && wb.reg_write && (wb.waddr != '0)) begin
         regs[wb.waddr] <= wb.wdata;
      end
   end

   // Same-cycle write-back is visible to the read
   always_comb begin
      if (rs == '0) begin
         rs_data = '0;
      end else if (wb.reg_write && (wb.waddr == rs)) begin
         rs_data = wb.wdata;
      end else begin
         rs_data = regs[rs];
      end
      if (rt == '0) begin
         rt_data = '0;
      end else if (wb.reg_write && (wb.waddr == rt)) begin
         rt_data = wb.wdata;
      end else begin
         rt_data = regs[rt];
      end
   end

   assign imm_ext = {{(DATA_W-16){if_id.instruction[15]}}, if_id.instruction[15:0]};

   //////////////////////////////
   // ID/EX register
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else if (enable) begin
         id_ex.ctrl       <= ctrl;
         id_ex.updated_pc <= if_id.updated_pc;
         id_ex.rs_data    <= rs_data;
         id_ex.rt_data    <= rt_data;
         id_ex.imm_ext    <= imm_ext;
         id_ex.rs         <= rs;
         id_ex.rt         <= rt;
         id_ex.rd         <= rd;
         id_ex.funct      <= if_id.instruction[5:0];
         id_ex.jump_index <= if_id.instruction[25:0];
      end
   end

endmodule

// File: src/execute_stage.sv
// Execute stage
`timescale 1ns/10ps

module execute_stage (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               enable,
   input  cpu_pkg::id_ex_t    id_ex,
   input  cpu_pkg::word_t     fwd_mem_result,
   input  cpu_pkg::reg_addr_t fwd_mem_waddr,
   input  logic               fwd_mem_reg_write,
   input  cpu_pkg::wb_t       wb,
   output cpu_pkg::ex_mem_t   ex_mem
);
   import cpu_pkg::*;

   word_t     op_a;
   word_t     rt_fwd;
   word_t     op_b;
   word_t     alu_result;
   logic      zero;
   alu_ctrl_e alu_ctrl;
   word_t     branch_pc;
   word_t     jump_pc;
   reg_addr_t waddr;

   //////////////////////////////
   // Forwarding
   //////////////////////////////
   // Newest producer first: EX/MEM, then write-back, then register value
   function automatic word_t fwd_select(reg_addr_t src, word_t reg_val);
      word_t val;
      if (fwd_mem_reg_write && (fwd_mem_waddr != '0) && (fwd_mem_waddr == src)) begin
         val = fwd_mem_result;
      end else if (wb.reg_write && (wb.waddr != '0) && (wb.waddr == src)) begin
         val = wb.wdata;
      end else begin
         val = reg_val;
      end
      return val;
   endfunction

   always_comb begin
      op_a   = fwd_select(id_ex.rs, id_ex.rs_data);
      rt_fwd = fwd_select(id_ex.rt, id_ex.rt_data);
   end

   assign op_b = id_ex.ctrl.alu_src ? id_ex.imm_ext : rt_fwd;

   //////////////////////////////
   // ALU control and ALU
   //////////////////////////////
   always_comb begin
      case (id_ex.ctrl.alu_op)
         ALUOP_ADD: alu_ctrl = AC_ADD;
         ALUOP_SUB: alu_ctrl = AC_SUB;
         ALUOP_FUNCT: begin
            case (id_ex.funct)
               F_ADD:   alu_ctrl = AC_ADD;
               F_SUB:   alu_ctrl = AC_SUB;
               F_AND:   alu_ctrl = AC_AND;
               F_OR:    alu_ctrl = AC_OR;
               F_SLT:   alu_ctrl = AC_SLT;
               // nop and unsupported functions fall here
               default: alu_ctrl = AC_ADD;
            endcase
         end
         default: alu_ctrl = AC_ADD;
      endcase
   end

   always_comb begin
      case (alu_ctrl)
         AC_AND:  alu_result = op_a & op_b;
         AC_OR:   alu_result = op_a | op_b;
         AC_ADD:  alu_result = op_a + op_b;
         AC_SUB:  alu_result = op_a - op_b;
         // Signed compare
         AC_SLT:  alu_result = {{(DATA_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
         default: alu_result = '0;
      endcase
   end

   assign zero = (alu_result == '0);

   //////////////////////////////
   // Targets and destination
   //////////////////////////////
   assign branch_pc = id_ex.updated_pc + {id_ex.imm_ext[DATA_W-3:0], 2'b00};
   assign jump_pc   = {id_ex.updated_pc[DATA_W-1:DATA_W-4], id_ex.jump_index, 2'b00};
   assign waddr     = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

   //////////////////////////////
   // EX/MEM register
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem.reg_write  <= id_ex.ctrl.reg_write;
         ex_mem.mem_2_reg  <= id_ex.ctrl.mem_2_reg;
         ex_mem.mem_read   <= id_ex.ctrl.mem_read;
         ex_mem.mem_write  <= id_ex.ctrl.mem_write;
         ex_mem.branch     <= id_ex.ctrl.branch;
         ex_mem.jump       <= id_ex.ctrl.jump;
         ex_mem.zero       <= zero;
         ex_mem.branch_pc  <= branch_pc;
         ex_mem.jump_pc    <= jump_pc;
         ex_mem.alu_result <= alu_result;
         ex_mem.store_data <= rt_fwd;
         ex_mem.waddr      <= waddr;
      end
   end

endmodule

// File: src/memory_stage.sv
// Memory access and write-back stage
`timescale 1ns/10ps

module memory_stage #(
   parameter int DMEM_ADDR_W = cpu_pkg::DMEM_ADDR_W
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   enable,
   input  cpu_pkg::ex_mem_t       ex_mem,
   input  logic                   dmem_wen,
   input  logic [DMEM_ADDR_W-1:0] dmem_addr,
   input  cpu_pkg::word_t         dmem_wdata,
   output cpu_pkg::word_t         dmem_rdata,
   output cpu_pkg::redirect_t     redirect,
   output cpu_pkg::word_t         fwd_mem_result,
   output cpu_pkg::reg_addr_t     fwd_mem_waddr,
   output logic                   fwd_mem_reg_write,
   output cpu_pkg::wb_t           wb
);
   import cpu_pkg::*;

   logic [DMEM_ADDR_W-1:0] pipe_addr;
   word_t                  load_data;
   mem_wb_t                mem_wb;

   word_t dmem [2**DMEM_ADDR_W];

   //////////////////////////////
   // Data memory
   //////////////////////////////
   assign pipe_addr = ex_mem.alu_result[DMEM_ADDR_W+1:2];

   // External port has priority on a shared edge
   always_ff @(posedge clk) begin
      if (dmem_wen) begin
         dmem[dmem_addr] <= dmem_wdata;
      end else if (enable && ex_mem.mem_write) begin
         dmem[pipe_addr] <= ex_mem.store_data;
      end
   end

   assign load_data  = ex_mem.mem_read ? dmem[pipe_addr] : '0;
   assign dmem_rdata = dmem[dmem_addr];

   // Redirect and EX/MEM forwarding taps
   assign redirect.take_branch = ex_mem.branch & ex_mem.zero;
   assign redirect.take_jump   = ex_mem.jump;
   assign redirect.branch_pc   = ex_mem.branch_pc;
   assign redirect.jump_pc     = ex_mem.jump_pc;

   assign fwd_mem_result    = ex_mem.alu_result;
   assign fwd_mem_waddr     = ex_mem.waddr;
   assign fwd_mem_reg_write = ex_mem.reg_write;

   //////////////////////////////
   // MEM/WB register
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_wb <= '0;
      end else if (enable) begin
         mem_wb.reg_write  <= ex_mem.reg_write;
         mem_wb.mem_2_reg  <= ex_mem.mem_2_reg;
         mem_wb.alu_result <= ex_mem.alu_result;
         mem_wb.load_data  <= load_data;
         mem_wb.waddr      <= ex_mem.waddr;
      end
   end

   // Write-back select
   assign wb.reg_write = mem_wb.reg_write;
   assign wb.waddr     = mem_wb.waddr;
   assign wb.wdata     = mem_wb.mem_2_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// File: src/cpu.sv
// Five-stage pipelined CPU top
`timescale 1ns/10ps

module cpu #(
   parameter int IMEM_ADDR_W = cpu_pkg::IMEM_ADDR_W,
   parameter int DMEM_ADDR_W = cpu_pkg::DMEM_ADDR_W
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   enable,
   input  logic                   imem_wen,
   input  logic [IMEM_ADDR_W-1:0] imem_addr,
   input  cpu_pkg::word_t         imem_wdata,
   input  logic                   dmem_wen,
   input  logic [DMEM_ADDR_W-1:0] dmem_addr,
   input  cpu_pkg::word_t         dmem_wdata,
   output cpu_pkg::word_t         dmem_rdata
);
   import cpu_pkg::*;

   if_id_t    if_id;
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   redirect_t redirect;
   wb_t       wb;
   word_t     fwd_mem_result;
   reg_addr_t fwd_mem_waddr;
   logic      fwd_mem_reg_write;

   //////////////////////////////
   // Pipeline stages
   //////////////////////////////
   fetch_stage #(
      .IMEM_ADDR_W(IMEM_ADDR_W)
   ) u_fetch (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .redirect  (redirect),
      .imem_wen  (imem_wen),
      .imem_addr (imem_addr),
      .imem_wdata(imem_wdata),
      .if_id     (if_id)
   );

   decode_stage u_decode (
      .clk   (clk),
      .arst_n(arst_n),
      .enable(enable),
      .if_id (if_id),
      .wb    (wb),
      .id_ex (id_ex)
   );

   execute_stage u_execute (
      .clk              (clk),
      .arst_n           (arst_n),
      .enable           (enable),
      .id_ex            (id_ex),
      .fwd_mem_result   (fwd_mem_result),
      .fwd_mem_waddr    (fwd_mem_waddr),
      .fwd_mem_reg_write(fwd_mem_reg_write),
      .wb               (wb),
      .ex_mem           (ex_mem)
   );

   // Also closes the redirect and write-back loops
   memory_stage #(
      .DMEM_ADDR_W(DMEM_ADDR_W)
   ) u_memory (
      .clk              (clk),
      .arst_n           (arst_n),
      .enable           (enable),
      .ex_mem           (ex_mem),
      .dmem_wen         (dmem_wen),
      .dmem_addr        (dmem_addr),
      .dmem_wdata       (dmem_wdata),
      .dmem_rdata       (dmem_rdata),
      .redirect         (redirect),
      .fwd_mem_result   (fwd_mem_result),
      .fwd_mem_waddr    (fwd_mem_waddr),
      .fwd_mem_reg_write(fwd_mem_reg_write),
      .wb               (wb)
   );

endmodule

// File: include/tb_programs.svh
// CPU test programs
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

word_t prog [$];

localparam word_t NOP = '0;

//////////////////////////////
// Encoders
//////////////////////////////
function automatic word_t enc_r(
   logic [5:0] funct,
   logic [4:0] rd,
   logic [4:0] rs,
   logic [4:0] rt
);
   return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

// rt is the destination, or the store source
function automatic word_t enc_i(
   logic [5:0]  op,
   logic [4:0]  rt,
   logic [4:0]  rs,
   logic [15:0] imm
);
   return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(logic [25:0] index);
   return {OP_J, index};
endfunction

task automatic emit(word_t instr);
   prog.push_back(instr);
endtask

//////////////////////////////
// Programs
//////////////////////////////
task automatic alu_program(logic [15:0] imm);
   int r;
   prog.delete();
   emit(enc_i(OP_LW, 5'd1, 5'd0, 16'd0));
   emit(enc_i(OP_LW, 5'd2, 5'd0, 16'd4));
   // Gap between lw and first use
   emit(NOP);
   emit(enc_r(F_ADD, 5'd3, 5'd1, 5'd2));
   emit(enc_r(F_SUB, 5'd4, 5'd1, 5'd2));
   emit(enc_r(F_AND, 5'd5, 5'd1, 5'd2));
   emit(enc_r(F_OR, 5'd6, 5'd1, 5'd2));
   emit(enc_r(F_SLT, 5'd7, 5'd1, 5'd2));
   emit(enc_i(OP_ADDI, 5'd8, 5'd1, imm));
   emit(enc_r(F_SLT, 5'd9, 5'd2, 5'd1));
   // r3..r9 land in words 16..22
   for (r = 3; r <= 9; r++) begin
      emit(enc_i(OP_SW, 5'(r), 5'd0, 16'(64 + 4 * (r - 3))));
   end
endtask

// Each add depends on the one before it
task automatic chain_program(logic [15:0] k, logic [15:0] base);
   prog.delete();
   emit(enc_i(OP_ADDI, 5'd1, 5'd0, k));
   emit(enc_r(F_ADD, 5'd2, 5'd1, 5'd1));
   emit(enc_i(OP_SW, 5'd2, 5'd0, base));
   emit(enc_r(F_ADD, 5'd3, 5'd2, 5'd1));
   emit(enc_i(OP_SW, 5'd3, 5'd0, base + 16'd4));
   emit(NOP);
   // r3 at distance 3
   emit(enc_r(F_ADD, 5'd4, 5'd3, 5'd2));
   emit(enc_i(OP_SW, 5'd4, 5'd0, base + 16'd8));
   emit(enc_r(F_ADD, 5'd5, 5'd4, 5'd3));
   emit(enc_i(OP_SW, 5'd5, 5'd0, base + 16'd12));
   emit(NOP);
   emit(enc_r(F_ADD, 5'd6, 5'd5, 5'd4));
   emit(enc_i(OP_SW, 5'd6, 5'd0, base + 16'd16));
endtask

task automatic copy_program(logic [15:0] v);
   prog.delete();
   emit(enc_i(OP_LW, 5'd1, 5'd0, 16'd160));
   emit(NOP);
   emit(enc_i(OP_SW, 5'd1, 5'd0, 16'd164));
   emit(enc_i(OP_ADDI, 5'd2, 5'd0, v));
   emit(enc_i(OP_SW, 5'd2, 5'd0, 16'd168));
   emit(enc_i(OP_LW, 5'd3, 5'd0, 16'd168));
   emit(NOP);
   emit(enc_r(F_ADD, 5'd4, 5'd3, 5'd1));
   emit(enc_i(OP_SW, 5'd4, 5'd0, 16'd172));
endtask

// Taken beq at 4, not-taken beq at 10, both aimed four slots ahead
task automatic branch_program(logic [15:0] eq, logic [15:0] m);
   int i;
   prog.delete();
   emit(enc_i(OP_ADDI, 5'd1, 5'd0, eq));
   emit(enc_i(OP_ADDI, 5'd2, 5'd0, eq));
   emit(enc_i(OP_ADDI, 5'd3, 5'd0, m));
   emit(enc_i(OP_ADDI, 5'd4, 5'd0, ~eq));
   emit(enc_i(OP_BEQ, 5'd2, 5'd1, 16'd4));
   for (i = 0; i < 5; i++) begin
      emit(enc_i(OP_SW, 5'd3, 5'd0, 16'(200 + 4 * i)));
   end
   emit(enc_i(OP_BEQ, 5'd4, 5'd1, 16'd4));
   for (i = 5; i < 10; i++) begin
      emit(enc_i(OP_SW, 5'd3, 5'd0, 16'(200 + 4 * i)));
   end
endtask

task automatic jump_program(logic [15:0] m);
   int i;
   prog.delete();
   emit(enc_i(OP_ADDI, 5'd3, 5'd0, m));
   emit(enc_j(26'd8));
   for (i = 0; i < 7; i++) begin
      emit(enc_i(OP_SW, 5'd3, 5'd0, 16'(240 + 4 * i)));
   end
endtask

`endif

// File: sim/tb_cpu.sv
// Pipelined CPU testbench
`timescale 1ns/10ps

module tb_cpu;
   import cpu_pkg::*;

   localparam int IMEM_AW = 9;
   localparam int DMEM_AW = 10;

   // Per test: imem load, preload, reset, run, readback
   localparam int MAX_PROG       = 17;
   localparam int MAX_WORDS      = 12;
   localparam int TEST_CYCLES    = (MAX_PROG + 13) + MAX_WORDS + 5
                                   + (MAX_PROG + 11) + 2 * MAX_WORDS;
   localparam int HOLD_CYCLES    = 10 + 2 * 5 + 1;
   localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES + HOLD_CYCLES + 50;

   logic               clk = 1'b0;
   logic               arst_n;
   logic               enable;
   logic               imem_wen;
   logic [IMEM_AW-1:0] imem_addr;
   word_t              imem_wdata;
   logic               dmem_wen;
   logic [DMEM_AW-1:0] dmem_addr;
   word_t              dmem_wdata;
   word_t              dmem_rdata;

   logic [15:0] lfsr;
   string       cur_test;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          cycle_count;
   word_t       chain_exp [5];

   `include "tb_programs.svh"

   cpu #(
      .IMEM_ADDR_W(IMEM_AW),
      .DMEM_ADDR_W(DMEM_AW)
   ) DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .imem_wen  (imem_wen),
      .imem_addr (imem_addr),
      .imem_wdata(imem_wdata),
      .dmem_wen  (dmem_wen),
      .dmem_addr (dmem_addr),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run timed out after %0d cycles before all tests finished", cycle_count);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic out_bit;
      logic fb;
      out_bit = lfsr[15];
      fb      = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr    = {lfsr[14:0], fb};
      return out_bit;
   endfunction

   function automatic word_t rand_bits(int n);
      word_t v;
      int    i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[DATA_W-2:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic word_t sext16(logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   // Preload marker, unique per word
   function automatic word_t fill_word(int addr);
      return 32'h5EED_0000 | 32'(addr);
   endfunction

   task automatic load_program();
      int i;
      // Program plus a nop tail that covers the run
      for (i = 0; i < prog.size() + 12; i++) begin
         @(negedge clk);
         imem_wen   = 1'b1;
         imem_addr  = IMEM_AW'(i);
         imem_wdata = (i < prog.size()) ? prog[i] : NOP;
      end
   endtask

   task automatic preload_word(int addr, word_t data);
      @(negedge clk);
      imem_wen   = 1'b0;
      dmem_wen   = 1'b1;
      dmem_addr  = DMEM_AW'(addr);
      dmem_wdata = data;
   endtask

   task automatic fill_words(int first, int count);
      int i;
      for (i = first; i < first + count; i++) begin
         preload_word(i, fill_word(i));
      end
   endtask

   task automatic pulse_reset();
      @(negedge clk);
      imem_wen = 1'b0;
      dmem_wen = 1'b0;
      arst_n   = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic run_cycles(int n);
      @(negedge clk);
      enable = 1'b1;
      repeat (n) @(negedge clk);
      enable = 1'b0;
   endtask

   //////////////////////////////
   // Checking
   //////////////////////////////
   task automatic check_word(int addr, word_t exp);
      word_t got;
      @(negedge clk);
      dmem_addr = DMEM_AW'(addr);
      @(negedge clk);
      got = dmem_rdata;
      assert (got === exp) else begin
         $display("FAIL %s word %0d: expected %h, actual %h", cur_test, addr, exp, got);
         test_errors++;
      end
   endtask

   task automatic begin_test(string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %-10s ok", cur_test);
      end else begin
         $display("test %-10s %0d mismatches", cur_test, test_errors);
         tests_failed++;
      end
   endtask

   // Register values of the add chain, r2..r6
   task automatic chain_model(logic [15:0] k);
      word_t r [7];
      int    i;
      r[1] = sext16(k);
      r[2] = r[1] + r[1];
      r[3] = r[2] + r[1];
      r[4] = r[3] + r[2];
      r[5] = r[4] + r[3];
      r[6] = r[5] + r[4];
      for (i = 0; i < 5; i++) begin
         chain_exp[i] = r[i + 2];
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////
   task automatic alu_and_addi();
      word_t       a;
      word_t       b;
      logic [15:0] imm;
      word_t       exp [7];
      int          i;
      begin_test("alu_addi");
      a      = rand_bits(32);
      // Opposite signs make slt differ from an unsigned compare
      b      = rand_bits(31);
      b[31]  = ~a[31];
      imm    = 16'(rand_bits(16));
      exp[0] = a + b;
      exp[1] = a - b;
      exp[2] = a & b;
      exp[3] = a | b;
      exp[4] = {31'd0, $signed(a) < $signed(b)};
      exp[5] = a + sext16(imm);
      exp[6] = {31'd0, $signed(b) < $signed(a)};
      alu_program(imm);
      load_program();
      preload_word(0, a);
      preload_word(1, b);
      fill_words(16, 7);
      pulse_reset();
      run_cycles(prog.size() + 10);
      for (i = 0; i < 7; i++) begin
         check_word(16 + i, exp[i]);
      end
      end_test();
   endtask

   task automatic forwarding_chain();
      logic [15:0] k;
      int          i;
      begin_test("forward");
      k = 16'(rand_bits(16));
      chain_model(k);
      chain_program(k, 16'd96);
      load_program();
      fill_words(24, 5);
      pulse_reset();
      run_cycles(prog.size() + 10);
      for (i = 0; i < 5; i++) begin
         check_word(24 + i, chain_exp[i]);
      end
      end_test();
   endtask

   task automatic load_store_copy();
      word_t       p;
      logic [15:0] v;
      begin_test("ld_st");
      p = rand_bits(32);
      v = 16'(rand_bits(16));
      copy_program(v);
      load_program();
      preload_word(40, p);
      fill_words(41, 3);
      pulse_reset();
      run_cycles(prog.size() + 10);
      check_word(41, p);
      check_word(42, sext16(v));
      check_word(43, sext16(v) + p);
      end_test();
   endtask

   task automatic branch_skips();
      logic [15:0] eq;
      logic [15:0] m;
      int          i;
      begin_test("branch");
      eq = 16'(rand_bits(16));
      m  = 16'(rand_bits(16));
      branch_program(eq, m);
      load_program();
      fill_words(50, 10);
      pulse_reset();
      run_cycles(prog.size() + 10);
      // Taken beq drops only the slot after its three followers
      for (i = 0; i < 10; i++) begin
         check_word(50 + i, (i == 3) ? fill_word(50 + i) : sext16(m));
      end
      end_test();
   endtask

   task automatic jump_skips();
      logic [15:0] m;
      int          i;
      begin_test("jump");
      m = 16'(rand_bits(16));
      jump_program(m);
      load_program();
      fill_words(60, 7);
      pulse_reset();
      run_cycles(prog.size() + 10);
      // Words 63..65 sit in the skipped block
      for (i = 0; i < 7; i++) begin
         check_word(60 + i, (i >= 3 && i <= 5) ? fill_word(60 + i) : sext16(m));
      end
      end_test();
   endtask

   task automatic enable_hold();
      logic [15:0] k;
      int          i;
      begin_test("hold");
      k = 16'(rand_bits(16));
      chain_model(k);
      chain_program(k, 16'd128);
      load_program();
      fill_words(32, 5);
      pulse_reset();
      // Seven edges retire the first store and leave the second one in EX/MEM
      run_cycles(7);
      repeat (10) @(negedge clk);
      for (i = 0; i < 5; i++) begin
         check_word(32 + i, (i < 1) ? chain_exp[i] : fill_word(32 + i));
      end
      run_cycles(prog.size() + 10 - 7);
      for (i = 0; i < 5; i++) begin
         check_word(32 + i, chain_exp[i]);
      end
      end_test();
   endtask

   initial begin
      arst_n       = 1'b0;
      enable       = 1'b0;
      imem_wen     = 1'b0;
      imem_addr    = '0;
      imem_wdata   = '0;
      dmem_wen     = 1'b0;
      dmem_addr    = '0;
      dmem_wdata   = '0;
      lfsr         = 16'd5;
      tests_run    = 0;
      tests_failed = 0;
      cycle_count  = 0;

      alu_and_addi();
      forwarding_chain();
      load_store_copy();
      branch_skips();
      jump_skips();
      enable_hold();

      $display("tests %0d, passed %0d, failed %0d",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_cpu -Mdir obj_dir \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_cpu > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } \
   || { echo "simulation passed"; exit 0; }
